//--- testbench/rv_mini_patterns.txt
# M addr word | R test pc rd data (rd 00 means no write)
# W test addr data sel (all numbers hex)
M 00000040 00500093
M 00000044 ffd08113
M 00000048 002081b3
M 0000004c 12345237
M 00000050 67820293
M 00000054 00108013
M 00000058 00100333
M 0000005c 800003b7
M 00000060 00738433
M 00000064 20000493
M 00000068 0054a023
M 0000006c 0004a503
M 00000070 0ab00593
M 00000074 00b48323
M 00000078 0064c603
M 0000007c 0014c683
M 00000080 0044a703
M 00000084 09500793
M 00000088 00478867
M 0000008c 00500093
M 00000090 00500093
M 00000094 00500093
M 00000098 000808b3
M 0000009c 00000000
M 000000a0 00100073
M 000000a4 00500093
R addi_pos 00000040 01 00000005
R addi_neg 00000044 02 00000002
R add_basic 00000048 03 00000007
R lui_basic 0000004c 04 12345000
R addi_big 00000050 05 12345678
R addi_x0 00000054 00 00000000
R add_x0 00000058 06 00000005
R lui_top 0000005c 07 80000000
R add_wrap 00000060 08 00000000
R addi_base 00000064 09 00000200
R sw_word 00000068 00 00000000
R lw_word 0000006c 0a 12345678
R addi_byte 00000070 0b 000000ab
R sb_byte 00000074 00 00000000
R lbu_hi 00000078 0c 000000ab
R lbu_lo 0000007c 0d 00000056
R lw_merge 00000080 0e 00ab0000
R addi_odd 00000084 0f 00000095
R jalr_link 00000088 10 0000008c
R add_link 00000098 11 0000008c
R unknown 0000009c 00 00000000
R ebreak 000000a0 00 00000000
W sw_word 00000200 12345678 f
W sb_byte 00000204 abababab 4

//--- rv_mini.f
src/rv_mini_pkg.sv
src/rv_mini_idu.sv
src/rv_mini_exu.sv
src/rv_mini_wbu.sv
src/rv_mini_regfile.sv
src/rv_mini_seq.sv
src/rv_mini_top.sv
testbench/rv_mini_monitor.sv
testbench/rv_mini_chk.sv
testbench/tb_rv_mini.sv

//--- Bender.yml
package:
  name: rv_mini

sources:
  - src/rv_mini_pkg.sv
  - src/rv_mini_idu.sv
  - src/rv_mini_exu.sv
  - src/rv_mini_wbu.sv
  - src/rv_mini_regfile.sv
  - src/rv_mini_seq.sv
  - src/rv_mini_top.sv
  - target: test
    files:
      - testbench/rv_mini_monitor.sv
      - testbench/rv_mini_chk.sv
      - testbench/tb_rv_mini.sv

//--- testbench/tb_rv_mini.sv
`default_nettype none

module tb_rv_mini import rv_mini_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam addr_t       RESET_PC     = 32'h0000_0040;
    localparam string       PATTERN_FILE = "testbench/rv_mini_patterns.txt";
    localparam int unsigned MEM_WORDS    = 1024;  // 4 KB model
    localparam int unsigned DRAIN_CYCLES = 20;    // Idle time after the last retire

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    retire_t retire;
    logic    halted;

    word_t       mem [0:MEM_WORDS-1];
    logic [31:0] lcg_state;
    int unsigned wait_left;      // Wait states still owed to the current request
    logic        busy;
    int unsigned n_retire_recs;
    int unsigned pattern_errors;

    rv_mini_top #(
        .RESET_PC (RESET_PC)
    ) i_rv_mini_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .retire (retire),
        .halted (halted)
    );

    rv_mini_monitor #(
        .RESET_PC (RESET_PC)
    ) i_rv_mini_monitor (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .retire (retire),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Memory model --------
    task automatic serve_request();
        int unsigned idx;
        idx = wb_req.adr[11:2];
        if (wb_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_req.sel[b]) mem[idx][8*b +: 8] = wb_req.dat_w[8*b +: 8];  // Lane write
            end
        end
        wb_rsp.dat_r = mem[idx];
        wb_rsp.ack   = 1'b1;
    endtask

    always @(negedge clk) begin
        if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;  // Taken at the last rising edge
            busy       = 1'b0;
        end else if (rst_n && wb_req.cyc && wb_req.stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = (lcg_next() >> 16) & 32'd3;  // 0 to 3 wait states
            end
            if (wait_left == 0) begin
                serve_request();
            end else begin
                wait_left--;
            end
        end
    end

    // Pattern reader --------
    task automatic load_patterns();
        int       fd;
        int       n;
        logic     ok;
        string    line;
        string    name;
        addr_t    a;
        word_t    d;
        reg_idx_t rd;
        sel_t     sel;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open pattern file %s", PATTERN_FILE);
            pattern_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
            case (line.getc(0))
                "M": begin
                    n  = $sscanf(line, "M %h %h", a, d);
                    ok = (n == 2);
                    if (ok) mem[a[11:2]] = d;
                end
                "R": begin
                    n  = $sscanf(line, "R %s %h %h %h", name, a, rd, d);
                    ok = (n == 4);
                    if (ok) begin
                        i_rv_mini_monitor.push_retire(name, a, rd, d);
                        n_retire_recs++;
                    end
                end
                "W": begin
                    n  = $sscanf(line, "W %s %h %h %h", name, a, d, sel);
                    ok = (n == 4);
                    if (ok) i_rv_mini_monitor.push_store(name, a, d, sel);
                end
                default: ok = 1'b0;
            endcase
            if (!ok) begin
                $display("Pattern line not understood: %s", line);
                pattern_errors++;
            end
        end
        $fclose(fd);
        if (n_retire_recs == 0) begin
            $display("Pattern file holds no retire records");
            pattern_errors++;
        end
    endtask

    task automatic run_watchdog();
        int unsigned limit;
        limit = n_retire_recs * 16 + 100;  // Cycles for the whole program
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the program finished", limit);
        $display("Some tests failed");
        $finish;
    endtask

    // Main sequence --------
    initial begin
        int unsigned assert_fails;
        int unsigned total;
        rst_n          = 1'b0;
        wb_rsp         = '0;
        busy           = 1'b0;
        wait_left      = 0;
        lcg_state      = 32'h3c43;
        n_retire_recs  = 0;
        pattern_errors = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
        load_patterns();

        if (pattern_errors == 0) begin
            fork
                run_watchdog();
            join_none
            repeat (8) @(posedge clk);  // Reset held 8 cycles
            @(negedge clk);
            rst_n = 1'b1;
            while (!(i_rv_mini_monitor.retires_pending() == 0 && halted)) begin
                @(negedge clk);
            end
            repeat (DRAIN_CYCLES) @(negedge clk);  // Catch late bus or retire activity
        end

        assert_fails = i_rv_mini_top.i_rv_mini_chk.fail_count;
        i_rv_mini_monitor.close_report(assert_fails, pattern_errors);
        total = i_rv_mini_monitor.error_total() + assert_fails + pattern_errors;
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/rv_mini_chk.sv
`default_nettype none

module rv_mini_chk import rv_mini_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    input  retire_t retire,
    input  logic    halted
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;  // Read by the testbench at the end

    // Wishbone master rules --------
    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> wb_req.cyc)
        else begin fail_count++; $error("stb high without cyc"); end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req))
        else begin fail_count++; $error("Request changed before ack"); end

    // Halt behaviour --------
    no_bus_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !wb_req.cyc)
        else begin fail_count++; $error("Bus cycle while halted"); end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin fail_count++; $error("halted dropped before reset"); end

    retire_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |=> !retire.valid)
        else begin fail_count++; $error("retire.valid high two cycles in a row"); end

endmodule

bind rv_mini_top rv_mini_chk i_rv_mini_chk (.*);

`default_nettype wire

//--- testbench/rv_mini_monitor.sv
`default_nettype none

module rv_mini_monitor import rv_mini_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    input  retire_t retire,
    input  logic    halted
);

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;    // Zero means no register write
        word_t    data;
    } exp_retire_t;

    typedef struct packed {
        addr_t adr;
        word_t dat;
        sel_t  sel;
    } exp_store_t;

    exp_retire_t exp_retire_q [$];
    string       retire_name_q [$];
    exp_store_t  exp_store_q [$];
    string       store_name_q [$];

    int unsigned mismatch_cnt = 0;
    int unsigned missing_cnt  = 0;
    int unsigned extra_cnt    = 0;
    int unsigned other_cnt    = 0;
    logic        reset_seen   = 1'b0;
    logic        first_req    = 1'b1;  // Still waiting for the first fetch

    task automatic push_retire(string name, addr_t pc, reg_idx_t rd, word_t data);
        exp_retire_q.push_back('{pc: pc, rd: rd, data: data});
        retire_name_q.push_back(name);
    endtask

    task automatic push_store(string name, addr_t adr, word_t dat, sel_t sel);
        exp_store_q.push_back('{adr: adr, dat: dat, sel: sel});
        store_name_q.push_back(name);
    endtask

    function automatic int unsigned retires_pending();
        return exp_retire_q.size();
    endfunction

    function automatic int unsigned error_total();
        return mismatch_cnt + missing_cnt + extra_cnt + other_cnt;
    endfunction

    task automatic compare_field(string name, string field, word_t exp, word_t act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("Mismatch %s %s: expected %h actual %h", name, field, exp, act);
        end
    endtask

    // Retire and store comparison --------
    task automatic check_retire();
        exp_retire_t exp;
        string       name;
        if (exp_retire_q.size() == 0) begin
            extra_cnt++;
            $display("Unexpected retire at pc %h after the last expected one", retire.pc);
            return;
        end
        exp  = exp_retire_q.pop_front();
        name = retire_name_q.pop_front();
        compare_field(name, "pc", exp.pc, retire.pc);
        compare_field(name, "reg_wen", word_t'(exp.rd != '0), word_t'(retire.reg_wen));
        if (exp.rd != '0) begin  // rd and data only mean something on a write
            compare_field(name, "rd", word_t'(exp.rd), word_t'(retire.rd));
            compare_field(name, "data", exp.data, retire.data);
        end
    endtask

    task automatic check_store();
        exp_store_t exp;
        string      name;
        if (exp_store_q.size() == 0) begin
            extra_cnt++;
            $display("Unexpected store to %h with data %h", wb_req.adr, wb_req.dat_w);
            return;
        end
        exp  = exp_store_q.pop_front();
        name = store_name_q.pop_front();
        compare_field(name, "adr", exp.adr, wb_req.adr);
        compare_field(name, "dat_w", exp.dat, wb_req.dat_w);
        compare_field(name, "sel", word_t'(exp.sel), word_t'(wb_req.sel));
    endtask

    // Sampled ahead of the DUT register updates
    always @(posedge clk) begin
        if (!rst_n) begin
            if (reset_seen && (wb_req.cyc !== 1'b0 || halted !== 1'b0)) begin
                other_cnt++;
                $display("Bus cycle or halted not low while in reset");
            end
            reset_seen = 1'b1;
            first_req  = 1'b1;
        end else begin
            if (first_req && wb_req.cyc) begin
                first_req = 1'b0;
                compare_field("reset_fetch", "adr", RESET_PC, wb_req.adr);
                compare_field("reset_fetch", "we", '0, word_t'(wb_req.we));
            end
            if (wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) check_store();
            if (retire.valid) check_retire();
        end
    end

    task automatic close_report(int unsigned assert_fails, int unsigned pattern_errors);
        while (exp_retire_q.size() != 0) begin
            void'(exp_retire_q.pop_front());
            $display("Missing retire for test %s", retire_name_q.pop_front());
            missing_cnt++;
        end
        while (exp_store_q.size() != 0) begin
            void'(exp_store_q.pop_front());
            $display("Missing store for test %s", store_name_q.pop_front());
            missing_cnt++;
        end
        if (!halted) begin
            other_cnt++;
            $display("Core is not halted at the end of the run");
        end
        $display({"Errors: %0d mismatch, %0d missing, %0d extra, %0d other, ",
                  "%0d assertion, %0d pattern"},
                 mismatch_cnt, missing_cnt, extra_cnt, other_cnt, assert_fails, pattern_errors);
    endtask

endmodule

`default_nettype wire

//--- src/rv_mini_top.sv
`default_nettype none

module rv_mini_top import rv_mini_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic    clk,
    input  logic    rst_n,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    output retire_t retire,
    output logic    halted
);

    // Internal nets --------
    decoded_t dec;
    exec_t    ex;
    word_t    inst;
    addr_t    pc;
    word_t    rdata1;
    word_t    rdata2;
    word_t    load_word;
    addr_t    mem_addr;
    word_t    store_dat;
    sel_t     store_sel;
    word_t    wb_data;
    logic     rf_wen;
    retire_t  seq_retire;

    rv_mini_seq #(
        .RESET_PC (RESET_PC)
    ) i_rv_mini_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .ex        (ex),
        .store_dat (store_dat),
        .store_sel (store_sel),
        .wb_rsp    (wb_rsp),
        .wb_req    (wb_req),
        .inst      (inst),
        .pc        (pc),
        .load_word (load_word),
        .mem_addr  (mem_addr),
        .rf_wen    (rf_wen),
        .retire    (seq_retire),
        .halted    (halted)
    );

    rv_mini_idu i_rv_mini_idu (
        .inst (inst),
        .dec  (dec)
    );

    rv_mini_regfile i_rv_mini_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (rf_wen),
        .waddr  (dec.rd),
        .wdata  (wb_data)
    );

    rv_mini_exu i_rv_mini_exu (
        .dec    (dec),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .pc     (pc),
        .ex     (ex)
    );

    rv_mini_wbu i_rv_mini_wbu (
        .ex        (ex),
        .rdata2    (rdata2),
        .load_word (load_word),
        .mem_addr  (mem_addr),
        .store_dat (store_dat),
        .store_sel (store_sel),
        .wb_data   (wb_data)
    );

    // Retire record carries the value written to the regfile
    always_comb begin
        retire      = seq_retire;
        retire.data = wb_data;
    end

endmodule

`default_nettype wire

//--- src/rv_mini_seq.sv
`default_nettype none

module rv_mini_seq import rv_mini_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic     clk,
    input  logic     rst_n,
    input  decoded_t dec,
    input  exec_t    ex,
    input  word_t    store_dat,
    input  sel_t     store_sel,
    input  wb_rsp_t  wb_rsp,
    output wb_req_t  wb_req,
    output word_t    inst,
    output addr_t    pc,
    output word_t    load_word,
    output addr_t    mem_addr,
    output logic     rf_wen,
    output retire_t  retire,
    output logic     halted
);

    seq_state_t state;
    exec_t      ex_q;        // Execute result held past S_EXEC

    // Bus control and payload registers
    logic  cyc_q;
    logic  stb_q;
    logic  we_q;
    addr_t adr_q;
    word_t dat_q;
    sel_t  sel_q;

    logic  ack;
    logic  issue_fetch;
    logic  issue_mem;

    assign ack         = cyc_q && stb_q && wb_rsp.ack;
    assign issue_fetch = (state == S_FETCH) && !cyc_q;  // First cycle of a fetch
    assign issue_mem   = (state == S_MEM) && !cyc_q;

    // Control path --------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_FETCH;
            pc    <= RESET_PC;
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            unique case (state)
                S_FETCH: begin
                    if (ack) begin
                        cyc_q <= 1'b0;  // Drop right after the ack edge
                        stb_q <= 1'b0;
                        state <= S_EXEC;
                    end else if (!cyc_q) begin
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                        we_q  <= 1'b0;
                    end
                end
                S_EXEC: state <= (ex.read || ex.write) ? S_MEM : S_RETIRE;
                S_MEM: begin
                    if (ack) begin
                        cyc_q <= 1'b0;
                        stb_q <= 1'b0;
                        we_q  <= 1'b0;
                        state <= S_RETIRE;
                    end else if (!cyc_q) begin
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                        we_q  <= ex_q.write;
                    end
                end
                S_RETIRE: begin
                    pc    <= ex_q.next_pc;
                    state <= ex_q.halt ? S_HALT : S_FETCH;
                end
                S_HALT:  state <= S_HALT;  // Only reset leaves
                default: state <= S_FETCH;
            endcase
        end
    end

    // Data path --------
    always_ff @(posedge clk) begin
        if (issue_fetch) begin
            adr_q <= pc;
            dat_q <= '0;
            sel_q <= '1;
        end
        if (issue_mem) begin
            adr_q <= {mem_addr[31:2], 2'b00};  // Word aligned, lanes via sel
            dat_q <= store_dat;
            sel_q <= store_sel;
        end
        if ((state == S_FETCH) && ack) begin
            inst <= wb_rsp.dat_r;               // Instruction register
        end
        if (state == S_EXEC) begin
            ex_q     <= ex;
            mem_addr <= ex.result;
        end
        if ((state == S_MEM) && ack) begin
            load_word <= wb_rsp.dat_r;
        end
    end

    assign wb_req = '{adr: adr_q, dat_w: dat_q, sel: sel_q, we: we_q, cyc: cyc_q, stb: stb_q};

    // Retire and halt outputs
    assign rf_wen = (state == S_RETIRE) && ex_q.reg_wen;
    assign halted = ((state == S_RETIRE) && ex_q.halt) || (state == S_HALT);

    always_comb begin
        retire.valid   = (state == S_RETIRE);
        retire.pc      = pc;           // Still the retiring instruction's PC
        retire.rd      = dec.rd;
        retire.reg_wen = ex_q.reg_wen;
        retire.data    = '0;           // Filled by the top from the writeback mux
    end

endmodule

`default_nettype wire

//--- src/rv_mini_regfile.sv
`default_nettype none

module rv_mini_regfile import rv_mini_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [1:31];  // x0 has no storage

    // Write port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Read ports, x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- src/rv_mini_wbu.sv
`default_nettype none

module rv_mini_wbu import rv_mini_pkg::*; (
    input  exec_t ex,
    input  word_t rdata2,
    input  word_t load_word,
    input  addr_t mem_addr,
    output word_t store_dat,
    output sel_t  store_sel,
    output word_t wb_data
);

    logic [1:0] byte_off;   // Lane within the word
    logic [7:0] load_byte;
    word_t      load_val;

    assign byte_off = mem_addr[1:0];

    // Store side --------
    always_comb begin
        if (ex.is_byte) begin
            store_dat = {4{rdata2[7:0]}};  // Same byte on every lane
        end else begin
            store_dat = rdata2;
        end

        // One lane for sb, full word for sw and all reads
        if (ex.write && ex.is_byte) begin
            store_sel = sel_t'(4'b0001 << byte_off);
        end else begin
            store_sel = 4'b1111;
        end
    end

    // Load side --------
    always_comb begin
        load_byte = load_word[{byte_off, 3'b000} +: 8];
        if (ex.is_byte) begin
            load_val = {24'b0, load_byte};  // lbu zero-extends
        end else begin
            load_val = load_word;
        end
    end

    // Writeback select
    // Loads take the bus word, jalr takes pc+4 and the rest take
    // the ALU result, both of which arrive through link
    always_comb begin
        if (ex.read) begin
            wb_data = load_val;
        end else begin
            wb_data = ex.link;
        end
    end

endmodule

`default_nettype wire

//--- src/rv_mini_exu.sv
`default_nettype none

module rv_mini_exu import rv_mini_pkg::*; (
    input  decoded_t dec,
    input  word_t    rdata1,
    input  word_t    rdata2,
    input  addr_t    pc,
    output exec_t    ex
);

    word_t sum_imm;   // rs1 + imm, shared by addi, jalr and memory ops
    addr_t pc_plus4;
    addr_t jalr_tgt;
    logic  wen;

    assign sum_imm  = rdata1 + dec.imm;
    assign pc_plus4 = pc + 32'd4;
    assign jalr_tgt = {sum_imm[31:1], 1'b0};  // Bit 0 cleared

    always_comb begin
        wen        = 1'b0;
        ex.result  = '0;
        ex.read    = 1'b0;
        ex.write   = 1'b0;
        ex.is_byte = 1'b0;
        ex.halt    = 1'b0;

        // Per-class behaviour --------
        unique case (1'b1)
            dec.inst_type[IT_ADDI]: begin
                ex.result = sum_imm;
                wen       = 1'b1;
            end
            dec.inst_type[IT_JALR]: begin
                ex.result = jalr_tgt;
                wen       = 1'b1;  // rd gets pc+4 through link
            end
            dec.inst_type[IT_EBREAK]: ex.halt = 1'b1;  // No writeback
            dec.inst_type[IT_ADD]: begin
                ex.result = rdata1 + rdata2;
                wen       = 1'b1;
            end
            dec.inst_type[IT_LUI]: begin
                ex.result = dec.imm;
                wen       = 1'b1;
            end
            dec.inst_type[IT_LW], dec.inst_type[IT_LBU]: begin
                ex.result  = sum_imm;  // Load address
                wen        = 1'b1;
                ex.read    = 1'b1;
                ex.is_byte = dec.inst_type[IT_LBU];
            end
            dec.inst_type[IT_SW], dec.inst_type[IT_SB]: begin
                ex.result  = sum_imm;  // Store address
                ex.write   = 1'b1;
                ex.is_byte = dec.inst_type[IT_SB];
            end
            default: ex.result = '0;  // Unknown word retires as a no-op
        endcase

        // Link equals result outside jalr
        ex.link    = dec.inst_type[IT_JALR] ? pc_plus4 : ex.result;
        ex.next_pc = dec.inst_type[IT_JALR] ? jalr_tgt : pc_plus4;
        ex.reg_wen = wen && (dec.rd != '0);  // x0 is never written
    end

endmodule

`default_nettype wire

//--- src/rv_mini_idu.sv
`default_nettype none

module rv_mini_idu import rv_mini_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    // Major opcodes
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam word_t      EBREAK_W  = 32'h0010_0073;  // Whole word match

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Immediate formats --------
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec.inst_type = '0;  // Unknown words keep all bits low
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm_i;   // I-type by default

        if (inst == EBREAK_W) begin
            dec.inst_type[IT_EBREAK] = 1'b1;
        end else begin
            unique case (opcode)
                OP_IMM:   dec.inst_type[IT_ADDI] = (funct3 == 3'b000);
                OP_JALR:  dec.inst_type[IT_JALR] = (funct3 == 3'b000);
                OP_REG:   dec.inst_type[IT_ADD]  = (funct3 == 3'b000) &&
                                                   (funct7 == 7'b0000000);
                OP_LUI: begin
                    dec.inst_type[IT_LUI] = 1'b1;
                    dec.imm               = imm_u;
                end
                OP_LOAD: begin
                    dec.inst_type[IT_LW]  = (funct3 == 3'b010);
                    dec.inst_type[IT_LBU] = (funct3 == 3'b100);
                end
                OP_STORE: begin
                    dec.inst_type[IT_SW] = (funct3 == 3'b010);
                    dec.inst_type[IT_SB] = (funct3 == 3'b000);
                    dec.imm              = imm_s;  // Split immediate
                end
                default: dec.inst_type = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/rv_mini_pkg.sv
`default_nettype none

package rv_mini_pkg;

    // Basic widths --------
    typedef logic [31:0] word_t;     // Data or instruction word
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [4:0]  reg_idx_t;  // Register index
    typedef logic [3:0]  sel_t;      // Wishbone byte lanes

    // One-hot instruction class
    localparam int unsigned N_INST_TYPES = 9;
    typedef logic [N_INST_TYPES-1:0] inst_type_t;

    localparam int unsigned IT_ADDI   = 0;
    localparam int unsigned IT_JALR   = 1;
    localparam int unsigned IT_EBREAK = 2;
    localparam int unsigned IT_ADD    = 3;
    localparam int unsigned IT_LUI    = 4;
    localparam int unsigned IT_LW     = 5;
    localparam int unsigned IT_LBU    = 6;
    localparam int unsigned IT_SW     = 7;
    localparam int unsigned IT_SB     = 8;

    // Sequencer states
    typedef enum logic [2:0] {
        S_FETCH,   // Instruction read on the bus
        S_EXEC,    // Decode and execute, one cycle
        S_MEM,     // Load or store on the bus
        S_RETIRE,  // Register write and retire pulse
        S_HALT     // Parked after ebreak
    } seq_state_t;

    // Bundles --------
    typedef struct packed {
        inst_type_t inst_type;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
    } decoded_t;

    typedef struct packed {
        word_t result;   // ALU value, also the memory address
        word_t link;     // Register value for non-load classes
        addr_t next_pc;
        logic  reg_wen;
        logic  read;
        logic  write;
        logic  is_byte;  // lbu or sb
        logic  halt;
    } exec_t;

    typedef struct packed {
        addr_t adr;
        word_t dat_w;
        sel_t  sel;
        logic  we;
        logic  cyc;
        logic  stb;
    } wb_req_t;

    typedef struct packed {
        word_t dat_r;
        logic  ack;
    } wb_rsp_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rd;
        logic     reg_wen;
        word_t    data;
    } retire_t;

endpackage

`default_nettype wire
